/* bcd_convert.sv */
module bcd_convert
   import front_panel_pkg::*;
(
   input  logic [SECONDS_W-1:0] binary,
   output logic [DIGIT_W-1:0]   hundreds,
   output logic [DIGIT_W-1:0]   tens,
   output logic [DIGIT_W-1:0]   ones
);

   // three digit columns sitting above the binary bits
   localparam int SCRATCH_W = 3 * DIGIT_W + SECONDS_W;

   logic [SCRATCH_W-1:0] scratch;

   ////////////////////////////////////////////////////////////
   // double dabble, one pass per input bit
   ////////////////////////////////////////////////////////////

   always_comb begin
      scratch = '0;
      scratch[SECONDS_W-1:0] = binary;
      for (int step = 0; step < SECONDS_W; step++) begin
         // a column of 5 or more would overflow past 9 on the shift
         for (int col = 0; col < 3; col++) begin
            if (scratch[SECONDS_W + col*DIGIT_W +: DIGIT_W] >= DIGIT_W'(5)) begin
               scratch[SECONDS_W + col*DIGIT_W +: DIGIT_W] =
                  scratch[SECONDS_W + col*DIGIT_W +: DIGIT_W] + DIGIT_W'(3);
            end
         end
         scratch = scratch << 1;
      end
   end

   assign ones     = scratch[SECONDS_W             +: DIGIT_W];
   assign tens     = scratch[SECONDS_W + DIGIT_W   +: DIGIT_W];
   assign hundreds = scratch[SECONDS_W + 2*DIGIT_W +: DIGIT_W];  // at most 2 for 8 bits

endmodule

/* front_panel.f */
front_panel_pkg.sv
input_debounce.sv
volume_control.sv
song_timer.sv
bcd_convert.sv
readout_sequencer.sv
front_panel.sv
tb_front_panel.sv

/* front_panel.sv */
module front_panel
   import front_panel_pkg::*;
#(
   parameter int DEBOUNCE_CYCLES   = DEBOUNCE_CYCLES_DEFAULT,
   parameter int CYCLES_PER_SECOND = CLOCK_HZ
) (
   input  logic                 clock_27mhz,
   input  logic                 reset,
   input  logic                 button_up,     // raw, active low
   input  logic                 button_down,   // raw, active low
   input  logic [SWITCH_W-1:0]  switch,        // raw slide switches
   input  logic                 start_song,
   input  logic                 pause_song,
   input  logic                 song_done,
   input  logic [SONG_W-1:0]    song_number,
   input  logic                 vsync,
   input  logic                 digit_ready,
   output logic [VOLUME_W-1:0]  volume,
   output logic [SECONDS_W-1:0] seconds,
   output logic                 digit_valid,
   output logic [DIGIT_W-1:0]   digit_value,
   output logic [SLOT_W-1:0]    digit_slot
);

   logic                up_clean;
   logic                down_clean;
   logic [SWITCH_W-1:0] switch_clean;
   logic [DIGIT_W-1:0]  sec_hundreds;
   logic [DIGIT_W-1:0]  sec_tens;
   logic [DIGIT_W-1:0]  sec_ones;
   logic [DIGIT_W-1:0]  song_tens;
   logic [DIGIT_W-1:0]  song_ones;

   ////////////////////////////////////////////////////////////
   // debounced user inputs
   ////////////////////////////////////////////////////////////

   input_debounce #(.SETTLE_CYCLES(DEBOUNCE_CYCLES)) debounce_up (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .noisy       (~button_up),      // pressed reads high from here on
      .clean       (up_clean)
   );

   input_debounce #(.SETTLE_CYCLES(DEBOUNCE_CYCLES)) debounce_down (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .noisy       (~button_down),
      .clean       (down_clean)
   );

   for (genvar i = 0; i < SWITCH_W; i++) begin : gen_switch_debounce
      input_debounce #(.SETTLE_CYCLES(DEBOUNCE_CYCLES)) debounce_switch (
         .clock_27mhz (clock_27mhz),
         .reset       (reset),
         .noisy       (switch[i]),
         .clean       (switch_clean[i])
      );
   end

   volume_control volume_control_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .up          (up_clean),
      .down        (down_clean),
      .volume      (volume)
   );

   song_timer #(.CYCLES_PER_SECOND(CYCLES_PER_SECOND)) song_timer_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .start_song  (start_song),
      .pause_song  (pause_song),
      .song_done   (song_done),
      .seconds     (seconds)
   );

   ////////////////////////////////////////////////////////////
   // decimal digits for the hud
   ////////////////////////////////////////////////////////////

   bcd_convert bcd_seconds (
      .binary   (seconds),
      .hundreds (sec_hundreds),
      .tens     (sec_tens),
      .ones     (sec_ones)
   );

   bcd_convert bcd_song (
      .binary   ({{(SECONDS_W-SONG_W){1'b0}}, song_number}),
      .hundreds (),                  // song numbers stop at 15
      .tens     (song_tens),
      .ones     (song_ones)
   );

   readout_sequencer readout_sequencer_inst (
      .clock_27mhz  (clock_27mhz),
      .reset        (reset),
      .vsync        (vsync),
      .sec_hundreds (sec_hundreds),
      .sec_tens     (sec_tens),
      .sec_ones     (sec_ones),
      .song_tens    (song_tens),
      .song_ones    (song_ones),
      .switch_clean (switch_clean),
      .digit_ready  (digit_ready),
      .digit_valid  (digit_valid),
      .digit_value  (digit_value),
      .digit_slot   (digit_slot)
   );

endmodule

/* front_panel_pkg.sv */
package front_panel_pkg;

   ////////////////////////////////////////////////////////////
   // word widths
   ////////////////////////////////////////////////////////////

   localparam int VOLUME_W  = 5;      // ac97 style attenuation step
   localparam int SECONDS_W = 8;      // elapsed seconds, saturates at 255
   localparam int SONG_W    = 4;      // song number from the player
   localparam int SWITCH_W  = 8;      // one slide switch per effect
   localparam int DIGIT_W   = 4;      // one decimal digit
   localparam int SLOT_W    = 4;      // hud glyph position

   ////////////////////////////////////////////////////////////
   // volume range
   ////////////////////////////////////////////////////////////

   localparam logic [VOLUME_W-1:0] VOLUME_RESET = 5'd8;   // comfortable start level
   localparam logic [VOLUME_W-1:0] VOLUME_MAX   = 5'd31;

   ////////////////////////////////////////////////////////////
   // hud slot map, left to right on the readout line
   ////////////////////////////////////////////////////////////

   // slots 0..6 belonged to the frequency and level readouts
   localparam logic [SLOT_W-1:0] SLOT_SEC_HUNDREDS = 4'd7;
   localparam logic [SLOT_W-1:0] SLOT_SEC_TENS     = 4'd8;
   localparam logic [SLOT_W-1:0] SLOT_SEC_ONES     = 4'd9;
   localparam logic [SLOT_W-1:0] SLOT_FX_COUNT     = 4'd11;  // slot 10 is a spacer
   localparam logic [SLOT_W-1:0] SLOT_SONG_TENS    = 4'd12;
   localparam logic [SLOT_W-1:0] SLOT_SONG_ONES    = 4'd13;

   ////////////////////////////////////////////////////////////
   // timing defaults for the 27 MHz board clock
   ////////////////////////////////////////////////////////////

   localparam int CLOCK_HZ = 27_000_000;                // cycles per second
   localparam int DEBOUNCE_CYCLES_DEFAULT = 270_000;     // 10 ms settle

endpackage

/* input_debounce.sv */
module input_debounce
   import front_panel_pkg::*;
#(
   parameter int SETTLE_CYCLES = DEBOUNCE_CYCLES_DEFAULT
) (
   input  logic clock_27mhz,
   input  logic reset,
   input  logic noisy,     // raw contact, may bounce
   output logic clean      // settled copy
);

   // counter must be able to hold SETTLE_CYCLES itself
   localparam int COUNT_W = $clog2(SETTLE_CYCLES + 1);

   logic [COUNT_W-1:0] settle_count;   // cycles noisy has disagreed with clean
   logic               settled;

   assign settled = (settle_count == COUNT_W'(SETTLE_CYCLES));

   // clean follows noisy only after a long enough disagreement;
   // any agreement in between restarts the wait
   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         settle_count <= '0;
         clean        <= 1'b0;
      end else if (noisy == clean) begin
         settle_count <= '0;               // bounce back, start over
      end else if (settled) begin
         clean        <= noisy;            // held long enough, take it
         settle_count <= '0;
      end else begin
         settle_count <= settle_count + 1'b1;
      end
   end

endmodule

/* readout_sequencer.sv */
module readout_sequencer
   import front_panel_pkg::*;
(
   input  logic                clock_27mhz,
   input  logic                reset,
   input  logic                vsync,          // low during vertical blank
   input  logic [DIGIT_W-1:0]  sec_hundreds,
   input  logic [DIGIT_W-1:0]  sec_tens,
   input  logic [DIGIT_W-1:0]  sec_ones,
   input  logic [DIGIT_W-1:0]  song_tens,
   input  logic [DIGIT_W-1:0]  song_ones,
   input  logic [SWITCH_W-1:0] switch_clean,   // one bit per enabled effect
   input  logic                digit_ready,    // hud writer can take a glyph
   output logic                digit_valid,
   output logic [DIGIT_W-1:0]  digit_value,
   output logic [SLOT_W-1:0]   digit_slot
);

   localparam logic [2:0] LAST_BEAT = 3'd5;   // six glyphs per sweep

   logic               vsync_q;
   logic               vsync_fall;
   logic               sweep_start;
   logic [2:0]         beat;           // which glyph is on the bus
   logic [DIGIT_W-1:0] switch_count;   // active effects

   // frozen copy for the whole sweep
   logic [DIGIT_W-1:0] snap_sec_hundreds;
   logic [DIGIT_W-1:0] snap_sec_tens;
   logic [DIGIT_W-1:0] snap_sec_ones;
   logic [DIGIT_W-1:0] snap_fx_count;
   logic [DIGIT_W-1:0] snap_song_tens;
   logic [DIGIT_W-1:0] snap_song_ones;

   assign vsync_fall  = vsync_q & ~vsync;
   assign sweep_start = vsync_fall & ~digit_valid;   // edges mid-sweep are dropped

   always_comb begin
      switch_count = '0;
      for (int i = 0; i < SWITCH_W; i++) begin
         switch_count = switch_count + DIGIT_W'(switch_clean[i]);
      end
   end

   ////////////////////////////////////////////////////////////
   // sweep control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         vsync_q     <= 1'b1;          // treat reset as active video
         digit_valid <= 1'b0;
         beat        <= '0;
      end else begin
         vsync_q <= vsync;
         if (sweep_start) begin
            digit_valid <= 1'b1;
            beat        <= '0;
         end else if (digit_valid && digit_ready) begin
            if (beat == LAST_BEAT) begin
               digit_valid <= 1'b0;    // song ones taken, wait for next blank
            end else begin
               beat <= beat + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clock_27mhz) begin
      if (sweep_start) begin
         snap_sec_hundreds <= sec_hundreds;
         snap_sec_tens     <= sec_tens;
         snap_sec_ones     <= sec_ones;
         snap_fx_count     <= switch_count;
         snap_song_tens    <= song_tens;
         snap_song_ones    <= song_ones;
      end
   end

   // beat to slot and glyph
   always_comb begin
      case (beat)
         3'd0:    begin digit_slot = SLOT_SEC_HUNDREDS; digit_value = snap_sec_hundreds; end
         3'd1:    begin digit_slot = SLOT_SEC_TENS;     digit_value = snap_sec_tens;     end
         3'd2:    begin digit_slot = SLOT_SEC_ONES;     digit_value = snap_sec_ones;     end
         3'd3:    begin digit_slot = SLOT_FX_COUNT;     digit_value = snap_fx_count;     end
         3'd4:    begin digit_slot = SLOT_SONG_TENS;    digit_value = snap_song_tens;    end
         default: begin digit_slot = SLOT_SONG_ONES;    digit_value = snap_song_ones;    end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // stalled glyph must not move under the hud writer
   beat_held_while_stalled: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      (digit_valid && !digit_ready) |=>
         (digit_valid && $stable(digit_value) && $stable(digit_slot))
   );

   // converters upstream only ever feed decimal digits, count tops out at 8
   glyph_in_range: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      digit_valid |-> ((digit_slot == SLOT_FX_COUNT) ?
                       (digit_value <= DIGIT_W'(SWITCH_W)) :
                       (digit_value <= DIGIT_W'(9)))
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the front panel testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_front_panel --Mdir obj_dir -o tb_front_panel \
   -f front_panel.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/tb_front_panel)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -q "All tests passed"; then
   exit 0
fi
exit 1

/* song_timer.sv */
module song_timer
   import front_panel_pkg::*;
#(
   parameter int CYCLES_PER_SECOND = CLOCK_HZ
) (
   input  logic                 clock_27mhz,
   input  logic                 reset,
   input  logic                 start_song,   // one cycle, restarts the count
   input  logic                 pause_song,   // level
   input  logic                 song_done,    // level, end of track
   output logic [SECONDS_W-1:0] seconds
);

   // a one-cycle second still needs a one bit prescaler
   localparam int PRESCALE_W = (CYCLES_PER_SECOND > 1) ? $clog2(CYCLES_PER_SECOND) : 1;
   localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(CYCLES_PER_SECOND - 1);

   logic [PRESCALE_W-1:0] prescale;    // running cycles within the current second
   logic                  running;
   logic                  second_tick;

   assign running     = ~pause_song & ~song_done;
   assign second_tick = running && (prescale == PRESCALE_LAST);

   ////////////////////////////////////////////////////////////
   // prescaler and seconds count
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         prescale <= '0;
         seconds  <= '0;
      end else if (start_song) begin
         prescale <= '0;              // new song, fresh second
         seconds  <= '0;
      end else if (running) begin
         if (second_tick) begin
            prescale <= '0;
            if (seconds != '1) begin
               seconds <= seconds + 1'b1;   // stop at 255
            end
         end else begin
            prescale <= prescale + 1'b1;
         end
      end
      // stopped: prescale keeps its partial second
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // paused or finished song must freeze the readout
   seconds_frozen_when_stopped: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      (!running && !start_song) |=> $stable(seconds)
   );

endmodule

/* tb_front_panel.sv */
module tb_front_panel
   import front_panel_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int SETTLE         = 4;        // debounce cycles for this build
   localparam int SECOND_TICKS   = 50;       // running cycles per second
   localparam int HOLD_CYCLES    = 10;       // press length and gap length
   localparam int GLITCH_CYCLES  = 2;        // well under the settle time
   localparam int GLITCHES       = 8;
   localparam int TIMER_CYCLES   = 8000;
   localparam int SWEEPS         = 10;       // per sweep test
   localparam int SWEEP_LIMIT    = 200;      // stuck handshake guard
   localparam int TIMEOUT_CYCLES = 20_000;   // about twice the summed test lengths
   localparam int DRIVE_DELAY    = 2;        // ns after the rising edge

   logic                 clock_27mhz;
   logic                 reset;
   logic                 button_up;
   logic                 button_down;
   logic [SWITCH_W-1:0]  switch;
   logic                 start_song;
   logic                 pause_song;
   logic                 song_done;
   logic [SONG_W-1:0]    song_number;
   logic                 vsync;
   logic                 digit_ready;
   logic [VOLUME_W-1:0]  volume;
   logic [SECONDS_W-1:0] seconds;
   logic                 digit_valid;
   logic [DIGIT_W-1:0]   digit_value;
   logic [SLOT_W-1:0]    digit_slot;

   int    model_prescale;   // running cycles in the current second
   int    model_seconds;
   int    model_volume;
   bit    hit_floor;        // a down press was clamped at 0
   bit    hit_ceiling;      // an up press was clamped at 31
   string test_name;
   int    test_errors;
   int    tests_run;
   int    tests_failed;
   int    total_errors;
   int    cycle_count;

   front_panel #(
      .DEBOUNCE_CYCLES   (SETTLE),
      .CYCLES_PER_SECOND (SECOND_TICKS)
   ) front_panel_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .button_up   (button_up),
      .button_down (button_down),
      .switch      (switch),
      .start_song  (start_song),
      .pause_song  (pause_song),
      .song_done   (song_done),
      .song_number (song_number),
      .vsync       (vsync),
      .digit_ready (digit_ready),
      .volume      (volume),
      .seconds     (seconds),
      .digit_valid (digit_valid),
      .digit_value (digit_value),
      .digit_slot  (digit_slot)
   );

   initial begin
      clock_27mhz = 1'b0;
      forever #10 clock_27mhz = ~clock_27mhz;   // 20 ns period
   end

   // hard stop in case a wait never ends
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clock_27mhz);
         cycle_count++;
      end
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // clocking and the seconds model
   ////////////////////////////////////////////////////////////

   // one edge, model sees the inputs that edge sampled
   task automatic tick();
      @(posedge clock_27mhz);
      if (reset || start_song) begin
         model_prescale = 0;
         model_seconds  = 0;
      end else if (!pause_song && !song_done) begin
         if (model_prescale == SECOND_TICKS - 1) begin
            model_prescale = 0;   // full second done
            model_seconds  = (model_seconds == 255) ? 255 : model_seconds + 1;
         end else begin
            model_prescale++;
         end
      end
      #DRIVE_DELAY;               // new inputs go out from here
   endtask

   task automatic ticks(input int count);
      repeat (count) tick();
   endtask

   ////////////////////////////////////////////////////////////
   // checks and bookkeeping
   ////////////////////////////////////////////////////////////

   task automatic check_equal(input string what, input int expected, input int actual);
      assert (expected == actual) else begin
         $display("mismatch in %s, %s: expected %0d, actual %0d",
                  test_name, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_true(input bit condition, input string problem);
      assert (condition) else begin
         $display("error in %s: %s", test_name, problem);
         test_errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s: passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, test_errors);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   // buttons are active low; release and wait out the gap
   task automatic press_button(input bit go_down, input int hold);
      if (go_down) begin
         button_down = 1'b0;
      end else begin
         button_up = 1'b0;
      end
      ticks(hold);
      button_up   = 1'b1;
      button_down = 1'b1;
      ticks(HOLD_CYCLES);
   endtask

   task automatic volume_presses(input int count, input int down_percent);
      bit go_down;
      for (int i = 0; i < count; i++) begin
         go_down = ($urandom_range(99) < down_percent);
         press_button(go_down, HOLD_CYCLES);
         if (go_down) begin
            hit_floor    |= (model_volume == 0);
            model_volume  = (model_volume == 0) ? 0 : model_volume - 1;
         end else begin
            hit_ceiling  |= (model_volume == 31);
            model_volume  = (model_volume == 31) ? 31 : model_volume + 1;
         end
         check_equal("volume after press", model_volume, int'(volume));
      end
   endtask

   task automatic timer_run(input int cycles);
      start_song = 1'b1;           // fresh song
      pause_song = 1'b0;
      song_done  = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         tick();
         check_equal("seconds", model_seconds, int'(seconds));
         start_song = ($urandom_range(2999) == 0);   // rare restart
         if ($urandom_range(29) == 0) begin
            pause_song = ($urandom_range(3) == 0);
            song_done  = ($urandom_range(7) == 0);
         end
      end
      start_song = 1'b0;
      pause_song = 1'b0;
      song_done  = 1'b0;
   endtask

   // one vertical blank, six beats expected in slot order
   task automatic sweep(input bit random_ready);
      int exp_slot[6];
      int exp_value[6];
      int ones;
      int accepted;
      int busy;
      int waited;
      switch      = SWITCH_W'($urandom);
      song_number = SONG_W'($urandom);
      ticks(SETTLE + 4);           // past the debounce latency
      ones = 0;
      for (int b = 0; b < SWITCH_W; b++) begin
         ones += switch[b];
      end
      exp_slot  = '{7, 8, 9, 11, 12, 13};
      exp_value = '{model_seconds / 100, (model_seconds / 10) % 10, model_seconds % 10,
                    ones, int'(song_number) / 10, int'(song_number) % 10};
      vsync       = 1'b0;          // blank starts
      digit_ready = random_ready ? 1'($urandom_range(1)) : 1'b1;
      accepted    = 0;
      busy        = 0;
      waited      = 0;
      while (accepted < 6 && waited < SWEEP_LIMIT) begin
         tick();
         waited++;
         if (waited == 2) vsync = 1'b1;     // second fall lands mid-sweep
         if (waited == 3) vsync = 1'b0;
         if (random_ready) begin
            digit_ready = 1'($urandom_range(1));
         end
         if (digit_valid) busy++;
         if (digit_valid && digit_ready) begin
            check_equal($sformatf("slot of beat %0d", accepted),
                        exp_slot[accepted], int'(digit_slot));
            check_equal($sformatf("value of beat %0d", accepted),
                        exp_value[accepted], int'(digit_value));
            accepted++;
         end
      end
      check_true(accepted == 6, $sformatf("sweep stopped after %0d of 6 beats", accepted));
      if (!random_ready) begin
         check_equal("sweep length in cycles", 6, busy);
      end
      digit_ready = 1'b1;          // any valid now would be a repeat
      for (int i = 0; i < 3; i++) begin
         tick();
         check_true(!digit_valid, "beat offered after the sixth transfer");
      end
      vsync = 1'b1;
      tick();
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h69439dd7));
      reset          = 1'b1;
      button_up      = 1'b1;       // released
      button_down    = 1'b1;
      switch         = '0;
      start_song     = 1'b0;
      pause_song     = 1'b0;
      song_done      = 1'b0;
      song_number    = '0;
      vsync          = 1'b1;       // active video
      digit_ready    = 1'b1;
      model_prescale = 0;
      model_seconds  = 0;
      model_volume   = 8;          // level after reset
      hit_floor      = 1'b0;
      hit_ceiling    = 1'b0;
      tests_run      = 0;
      tests_failed   = 0;
      total_errors   = 0;
      ticks(2);
      reset = 1'b0;

      begin_test("reset_values");
      check_equal("volume", 8, int'(volume));
      check_equal("seconds", 0, int'(seconds));
      check_equal("digit_valid", 0, int'(digit_valid));
      end_test();

      begin_test("volume_presses");
      volume_presses(24, 90);      // drive toward the floor
      volume_presses(48, 5);       // then up to the ceiling
      volume_presses(12, 50);
      for (int i = 0; i < GLITCHES; i++) begin
         press_button($urandom_range(1) == 1, GLITCH_CYCLES);
         check_equal("volume after glitch", model_volume, int'(volume));
      end
      check_true(hit_floor, "volume never saturated at 0");
      check_true(hit_ceiling, "volume never saturated at 31");
      end_test();

      begin_test("song_timer");
      timer_run(TIMER_CYCLES);
      end_test();

      begin_test("sweep_ready_high");
      repeat (SWEEPS) sweep(1'b0);
      end_test();

      begin_test("sweep_backpressure");
      repeat (SWEEPS) sweep(1'b1);
      end_test();

      $display("%0d tests run, %0d failed, %0d errors in total",
               tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* volume_control.sv */
module volume_control
   import front_panel_pkg::*;
(
   input  logic                clock_27mhz,
   input  logic                reset,
   input  logic                up,       // debounced, active high
   input  logic                down,     // debounced, active high
   output logic [VOLUME_W-1:0] volume
);

   logic up_q;        // last cycle's buttons
   logic down_q;
   logic up_rise;
   logic down_rise;

   assign up_rise   = up & ~up_q;
   assign down_rise = down & ~down_q;

   ////////////////////////////////////////////////////////////
   // one step per press, clamped at both ends
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         up_q   <= 1'b0;
         down_q <= 1'b0;
         volume <= VOLUME_RESET;
      end else begin
         up_q   <= up;
         down_q <= down;
         if (down_rise) begin
            // down press swallows a simultaneous up press
            if (volume != '0) begin
               volume <= volume - 1'b1;
            end
         end else if (up_rise && (volume != VOLUME_MAX)) begin
            volume <= volume + 1'b1;
         end
      end
   end

   // codec would misread a wrap from the top step to silence or back
   volume_single_step: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      1'b1 |=> ((int'(volume) >= int'($past(volume)) - 1) &&
                (int'(volume) <= int'($past(volume)) + 1))
   );

endmodule
